// ==== Makefile ====
TOP := booth_mul_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f build.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
+incdir+test
logic/mul_arith_pkg.sv
logic/mul_if_pkg.sv
logic/booth_radix4_recoder.sv
logic/booth_mul_core.sv
logic/mul_req_slave.sv
logic/booth_mul_top.sv
test/booth_mul_tb.sv

// ==== logic/booth_mul_core.sv ====
module booth_mul_core #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  mul_if_pkg::mul_ctrl_t         i_ctrl,
    input  logic [DATA_WIDTH - 1     : 0] i_num_a,
    input  logic [DATA_WIDTH - 1     : 0] i_num_b,
    output logic                          o_done,
    output logic [DATA_WIDTH * 2 - 1 : 0] o_res
);

    import mul_if_pkg::*;
    import mul_arith_pkg::*;

    // two extra bits let booth recoding treat unsigned operands as positive.
    localparam int EXT_WIDTH = DATA_WIDTH + 2;
    localparam int PP_WIDTH  = EXT_WIDTH * 2;
    localparam int STEPS     = EXT_WIDTH / 2;
    localparam int CNT_WIDTH = $clog2(STEPS + 1);

    logic [EXT_WIDTH - 1 : 0] w_ext_a;
    logic [EXT_WIDTH - 1 : 0] w_ext_b;

    logic [PP_WIDTH - 1 : 0]  r_mcand;
    logic [EXT_WIDTH : 0]     r_mplr;
    logic [PP_WIDTH - 1 : 0]  r_acc;
    logic [CNT_WIDTH - 1 : 0] r_count;
    logic                     r_busy;

    booth_sel_t               w_sel;
    logic [PP_WIDTH - 1 : 0]  w_partial;
    logic                     w_finish;

    always_comb begin
        if (i_ctrl.mode == MUL_SIGNED) begin
            w_ext_a = {{2{i_num_a[DATA_WIDTH - 1]}}, i_num_a};
            w_ext_b = {{2{i_num_b[DATA_WIDTH - 1]}}, i_num_b};
        end else begin
            w_ext_a = {2'b00, i_num_a};
            w_ext_b = {2'b00, i_num_b};
        end
    end

    booth_radix4_recoder #(
        .PP_WIDTH (PP_WIDTH)
    ) booth_radix4_recoder_inst (
        .i_triplet      (r_mplr[BOOTH_DIGIT_BITS - 1 : 0]),
        .i_multiplicand (r_mcand),
        .o_sel          (w_sel),
        .o_partial      (w_partial)
    );

    // stop at the digit limit or once no multiplier bits remain.
    assign w_finish = (r_count == CNT_WIDTH'(STEPS)) || (r_mplr == '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_busy  <= 1'b0;
            r_count <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_ctrl.start) begin
                r_busy  <= 1'b1;
                r_count <= '0;
            end else if (r_busy) begin
                if (w_finish) begin
                    r_busy <= 1'b0;
                    o_done <= 1'b1;
                end else begin
                    r_count <= r_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ctrl.start) begin
            r_mcand <= {{EXT_WIDTH{w_ext_a[EXT_WIDTH - 1]}}, w_ext_a};
            r_mplr  <= {w_ext_b, 1'b0};
            r_acc   <= '0;
        end else if (r_busy && !w_finish) begin
            // zero digits leave the accumulator alone.
            if (w_sel.one || w_sel.two) begin
                r_acc <= r_acc + w_partial;
            end
            r_mcand <= r_mcand << BOOTH_SHIFT;
            r_mplr  <= r_mplr >> BOOTH_SHIFT;
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_busy && w_finish) begin
            o_res <= r_acc[DATA_WIDTH * 2 - 1 : 0];
        end
    end

    a_no_start_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_ctrl.start |-> !r_busy
    ) else $error("start arrived while a multiplication is in flight");

    a_count_limit: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        r_count <= CNT_WIDTH'(STEPS)
    ) else $error("step count passed the digit limit");

    a_width_ok: assert property (
        @(posedge i_clk)
        (DATA_WIDTH % 2 == 0) && (DATA_WIDTH <= MUL_MAX_WIDTH)
    ) else $error("DATA_WIDTH must be even and within MUL_MAX_WIDTH");

endmodule

// ==== logic/booth_mul_top.sv ====
module booth_mul_top #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_req,
    input  mul_if_pkg::mul_mode_t         i_mode,
    input  logic [DATA_WIDTH - 1     : 0] i_num_a,
    input  logic [DATA_WIDTH - 1     : 0] i_num_b,
    output logic                          o_ack,
    output logic [DATA_WIDTH * 2 - 1 : 0] o_res
);

    import mul_if_pkg::*;

    mul_ctrl_t                     w_ctrl;
    logic [DATA_WIDTH - 1     : 0] w_num_a;
    logic [DATA_WIDTH - 1     : 0] w_num_b;
    logic                          w_done;
    logic [DATA_WIDTH * 2 - 1 : 0] w_prod;

    mul_req_slave #(
        .DATA_WIDTH (DATA_WIDTH)
    ) mul_req_slave_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (i_req),
        .i_mode  (i_mode),
        .i_num_a (i_num_a),
        .i_num_b (i_num_b),
        .i_done  (w_done),
        .i_prod  (w_prod),
        .o_ack   (o_ack),
        .o_ctrl  (w_ctrl),
        .o_num_a (w_num_a),
        .o_num_b (w_num_b),
        .o_res   (o_res)
    );

    booth_mul_core #(
        .DATA_WIDTH (DATA_WIDTH)
    ) booth_mul_core_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctrl  (w_ctrl),
        .i_num_a (w_num_a),
        .i_num_b (w_num_b),
        .o_done  (w_done),
        .o_res   (w_prod)
    );

endmodule

// ==== logic/booth_radix4_recoder.sv ====
module booth_radix4_recoder #(
    parameter int PP_WIDTH = 20
) (
    input  logic [mul_arith_pkg::BOOTH_DIGIT_BITS - 1 : 0] i_triplet,
    input  logic [PP_WIDTH - 1 : 0]                        i_multiplicand,
    output mul_arith_pkg::booth_sel_t                      o_sel,
    output logic [PP_WIDTH - 1 : 0]                        o_partial
);

    logic [PP_WIDTH - 1 : 0] w_mag;

    always_comb begin
        unique case (i_triplet)
            3'b001,
            3'b010: o_sel = '{neg: 1'b0, two: 1'b0, one: 1'b1};
            3'b011: o_sel = '{neg: 1'b0, two: 1'b1, one: 1'b0};
            3'b100: o_sel = '{neg: 1'b1, two: 1'b1, one: 1'b0};
            3'b101,
            3'b110: o_sel = '{neg: 1'b1, two: 1'b0, one: 1'b1};
            // 000 and 111 add nothing.
            default: o_sel = '{neg: 1'b0, two: 1'b0, one: 1'b0};
        endcase
    end

    always_comb begin
        if (o_sel.two) begin
            w_mag = i_multiplicand << 1;
        end else if (o_sel.one) begin
            w_mag = i_multiplicand;
        end else begin
            w_mag = '0;
        end
    end

    // two's complement when the digit is negative.
    assign o_partial = o_sel.neg ? (~w_mag + 1'b1) : w_mag;

    always_comb begin
        assert final (!(o_sel.one && o_sel.two))
            else $error("recoder selected both one and two times multiplicand");
    end

endmodule

// ==== logic/mul_arith_pkg.sv ====
package mul_arith_pkg;

    // bits of multiplier examined per booth digit.
    localparam int BOOTH_DIGIT_BITS = 3;

    // multiplier and multiplicand move by this much per digit.
    localparam int BOOTH_SHIFT = 2;

    // selection decoded from one triplet.
    // neither one nor two set means a zero partial product.
    typedef struct packed {
        logic neg;
        logic two;
        logic one;
    } booth_sel_t;

endpackage

// ==== logic/mul_if_pkg.sv ====
package mul_if_pkg;

    // widest operand the unit is checked for.
    localparam int MUL_MAX_WIDTH = 32;

    typedef enum logic {
        MUL_SIGNED   = 1'b0,
        MUL_UNSIGNED = 1'b1
    } mul_mode_t;

    // front end to core, start is a single-cycle pulse.
    typedef struct packed {
        logic      start;
        mul_mode_t mode;
    } mul_ctrl_t;

endpackage

// ==== logic/mul_req_slave.sv ====
module mul_req_slave #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_req,
    input  mul_if_pkg::mul_mode_t         i_mode,
    input  logic [DATA_WIDTH - 1     : 0] i_num_a,
    input  logic [DATA_WIDTH - 1     : 0] i_num_b,
    input  logic                          i_done,
    input  logic [DATA_WIDTH * 2 - 1 : 0] i_prod,
    output logic                          o_ack,
    output mul_if_pkg::mul_ctrl_t         o_ctrl,
    output logic [DATA_WIDTH - 1     : 0] o_num_a,
    output logic [DATA_WIDTH - 1     : 0] o_num_b,
    output logic [DATA_WIDTH * 2 - 1 : 0] o_res
);

    import mul_if_pkg::*;

    typedef enum logic [1 : 0] {
        ST_IDLE = 2'd0,
        ST_WAIT = 2'd1,
        ST_ACK  = 2'd2
    } state_t;

    state_t r_state;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state <= ST_IDLE;
            o_ctrl  <= '{start: 1'b0, mode: MUL_SIGNED};
        end else begin
            o_ctrl.start <= 1'b0;
            unique case (r_state)
                ST_IDLE: begin
                    if (i_req) begin
                        o_ctrl  <= '{start: 1'b1, mode: i_mode};
                        r_state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (i_done) begin
                        r_state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // hold until the requester lets go.
                    if (!i_req) begin
                        r_state <= ST_IDLE;
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_state == ST_IDLE && i_req) begin
            o_num_a <= i_num_a;
            o_num_b <= i_num_b;
        end
        if (r_state == ST_WAIT && i_done) begin
            o_res <= i_prod;
        end
    end

    assign o_ack = (r_state == ST_ACK);

    a_operands_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_req && !o_ack) ##1 (i_req && !o_ack) |-> $stable({i_mode, i_num_a, i_num_b})
    ) else $error("operands changed while a request was pending");

    a_res_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_ack ##1 o_ack |-> $stable(o_res)
    ) else $error("result changed while acknowledged");

    a_done_in_wait: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_done |-> (r_state == ST_WAIT)
    ) else $error("core finished outside the wait state");

endmodule

// ==== test/booth_mul_vectors.svh ====
`ifndef BOOTH_MUL_VECTORS_SVH
`define BOOTH_MUL_VECTORS_SVH

// columns: operand mode, operand a, operand b, expected product.
// products worked out by hand for 8-bit operands.

localparam int NUM_VECTORS = 24;

vector_t vectors [NUM_VECTORS];

task automatic load_vectors();
    // signed corners and mixed signs.
    vectors[0]  = '{mode: MUL_SIGNED,   a: 8'h80, b: 8'h80, prod: 16'h4000};
    vectors[1]  = '{mode: MUL_SIGNED,   a: 8'h80, b: 8'h7f, prod: 16'hc080};
    vectors[2]  = '{mode: MUL_SIGNED,   a: 8'hff, b: 8'hff, prod: 16'h0001};
    vectors[3]  = '{mode: MUL_SIGNED,   a: 8'h7f, b: 8'h7f, prod: 16'h3f01};
    vectors[4]  = '{mode: MUL_SIGNED,   a: 8'hfb, b: 8'h07, prod: 16'hffdd};
    vectors[5]  = '{mode: MUL_SIGNED,   a: 8'h0c, b: 8'hfd, prod: 16'hffdc};
    vectors[6]  = '{mode: MUL_SIGNED,   a: 8'h7f, b: 8'h80, prod: 16'hc080};
    vectors[7]  = '{mode: MUL_SIGNED,   a: 8'h00, b: 8'hff, prod: 16'h0000};
    vectors[8]  = '{mode: MUL_SIGNED,   a: 8'hff, b: 8'h01, prod: 16'hffff};
    // 100 * -100.
    vectors[9]  = '{mode: MUL_SIGNED,   a: 8'h64, b: 8'h9c, prod: 16'hd8f0};

    // unsigned, where the signed reading of the bits would differ.
    vectors[10] = '{mode: MUL_UNSIGNED, a: 8'hff, b: 8'hff, prod: 16'hfe01};
    vectors[11] = '{mode: MUL_UNSIGNED, a: 8'h80, b: 8'h02, prod: 16'h0100};
    vectors[12] = '{mode: MUL_UNSIGNED, a: 8'hc8, b: 8'h03, prod: 16'h0258};
    vectors[13] = '{mode: MUL_UNSIGNED, a: 8'hff, b: 8'h01, prod: 16'h00ff};
    vectors[14] = '{mode: MUL_UNSIGNED, a: 8'h81, b: 8'hfe, prod: 16'h7ffe};
    vectors[15] = '{mode: MUL_UNSIGNED, a: 8'haa, b: 8'h55, prod: 16'h3872};

    // zero and small multipliers, these leave the loop early.
    vectors[16] = '{mode: MUL_SIGNED,   a: 8'h5a, b: 8'h00, prod: 16'h0000};
    vectors[17] = '{mode: MUL_UNSIGNED, a: 8'hff, b: 8'h00, prod: 16'h0000};
    vectors[18] = '{mode: MUL_SIGNED,   a: 8'hb3, b: 8'h01, prod: 16'hffb3};
    vectors[19] = '{mode: MUL_SIGNED,   a: 8'h7f, b: 8'h02, prod: 16'h00fe};
    vectors[20] = '{mode: MUL_UNSIGNED, a: 8'hf0, b: 8'h03, prod: 16'h02d0};
    vectors[21] = '{mode: MUL_SIGNED,   a: 8'h80, b: 8'h00, prod: 16'h0000};
    vectors[22] = '{mode: MUL_SIGNED,   a: 8'h19, b: 8'h04, prod: 16'h0064};
    vectors[23] = '{mode: MUL_UNSIGNED, a: 8'h00, b: 8'hff, prod: 16'h0000};
endtask

`endif

// ==== test/booth_mul_tb.sv ====
module booth_mul_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mul_if_pkg::*;

    localparam int DATA_WIDTH   = 8;
    localparam int PROD_WIDTH   = DATA_WIDTH * 2;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 4;
    localparam int NUM_RANDOM   = 200;
    localparam int MAX_HOLD     = 3;

    typedef struct packed {
        mul_mode_t                 mode;
        logic [DATA_WIDTH - 1 : 0] a;
        logic [DATA_WIDTH - 1 : 0] b;
        logic [PROD_WIDTH - 1 : 0] prod;
    } vector_t;

    `include "booth_mul_vectors.svh"

    localparam int NUM_CASES      = NUM_VECTORS + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = NUM_CASES * (DATA_WIDTH / 2 + 8 + MAX_HOLD)
                                    + RESET_CYCLES + IDLE_CYCLES;

    logic                      i_clk = 1'b0;
    logic                      i_rst_n;
    logic                      i_req;
    mul_mode_t                 i_mode;
    logic [DATA_WIDTH - 1 : 0] i_num_a;
    logic [DATA_WIDTH - 1 : 0] i_num_b;
    logic                      o_ack;
    logic [PROD_WIDTH - 1 : 0] o_res;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    booth_mul_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) booth_mul_top_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (i_req),
        .i_mode  (i_mode),
        .i_num_a (i_num_a),
        .i_num_b (i_num_b),
        .o_ack   (o_ack),
        .o_res   (o_res)
    );

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the handshake never completed", cycle_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped by timeout");
        end
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [PROD_WIDTH - 1 : 0] reference_product(
        input mul_mode_t                 mode,
        input logic [DATA_WIDTH - 1 : 0] a,
        input logic [DATA_WIDTH - 1 : 0] b
    );
        int wide_a;
        int wide_b;
        if (mode == MUL_SIGNED) begin
            wide_a = int'($signed(a));
            wide_b = int'($signed(b));
        end else begin
            wide_a = int'(a);
            wide_b = int'(b);
        end
        return PROD_WIDTH'(wide_a * wide_b);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // one full four-phase transaction started just after a rising edge.
    task automatic run_request(input mul_mode_t mode, input logic [DATA_WIDTH - 1 : 0] a,
                               input logic [DATA_WIDTH - 1 : 0] b,
                               input logic [PROD_WIDTH - 1 : 0] expected, input int hold);
        check_value("o_ack", 32'(o_ack), 32'd0);
        i_mode  = mode;
        i_num_a = a;
        i_num_b = b;
        i_req   = 1'b1;
        do begin
            @(posedge i_clk);
            #1;
        end while (!o_ack);
        check_value("o_res", 32'(o_res), 32'(expected));
        // response must hold while the requester lingers.
        repeat (hold) begin
            @(posedge i_clk);
            #1;
            check_value("o_ack", 32'(o_ack), 32'd1);
            check_value("o_res", 32'(o_res), 32'(expected));
        end
        i_req = 1'b0;
        while (o_ack) begin
            @(posedge i_clk);
            #1;
            if (o_ack) begin
                check_value("o_res", 32'(o_res), 32'(expected));
            end
        end
    endtask

    initial begin
        vector_t     vec;
        mul_mode_t   mode;
        logic [31:0] rnd_mode;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        logic [31:0] rnd_hold;

        i_rst_n    = 1'b0;
        i_req      = 1'b0;
        i_mode     = MUL_SIGNED;
        i_num_a    = '0;
        i_num_b    = '0;
        lfsr_state = 32'h45e;
        load_vectors();

        repeat (RESET_CYCLES) begin
            @(posedge i_clk);
            #1;
            check_value("o_ack", 32'(o_ack), 32'd0);
        end
        i_rst_n = 1'b1;
        repeat (IDLE_CYCLES) begin
            @(posedge i_clk);
            #1;
            check_value("o_ack", 32'(o_ack), 32'd0);
        end

        for (int i = 0; i < NUM_VECTORS; i++) begin
            vec = vectors[i];
            run_request(vec.mode, vec.a, vec.b, vec.prod, i % (MAX_HOLD + 1));
        end

        // back-to-back random pairs in both modes.
        for (int i = 0; i < NUM_RANDOM; i++) begin
            draw_bits(1, rnd_mode);
            draw_bits(DATA_WIDTH, rnd_a);
            draw_bits(DATA_WIDTH, rnd_b);
            draw_bits(2, rnd_hold);
            mode = mul_mode_t'(rnd_mode[0]);
            run_request(mode, rnd_a[DATA_WIDTH - 1 : 0], rnd_b[DATA_WIDTH - 1 : 0],
                        reference_product(mode, rnd_a[DATA_WIDTH - 1 : 0],
                                          rnd_b[DATA_WIDTH - 1 : 0]),
                        int'(rnd_hold[1:0]));
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
